// ==== filelist.f ====
source/dwc_pkg.sv
source/dwc_write_splitter.sv
source/dwc_read_assembler.sv
source/dwc_narrow_arbiter.sv
source/dwc_downsizer_top.sv
verification/dwc_downsizer_checker.sv
verification/tb_dwc_downsizer.sv

// ==== verification/tb_dwc_downsizer.sv ====
// ######################################
// Downsizer testbench
// Wide writes and reads against a narrow
// memory model with random back-pressure
// ######################################

module tb_dwc_downsizer;
  timeunit 1ns;
  timeprecision 100ps;

  // Loop sizes of the test phases
  localparam int N_FULL = 4;
  localparam int N_PART = 6;
  localparam int N_NBP = 6;
  localparam int N_PAR = 8;
  // Wide transactions over all phases with each read-back counted as one
  localparam int NUM_TXN = 2 * N_FULL + 2 * N_PART + 2 + 2 * N_NBP + 6 * N_PAR;
  localparam int TIMEOUT_CYCLES = 60 * NUM_TXN + 200;
  localparam int MEM_WORDS = 256;
  localparam int LINES = MEM_WORDS / dwc_pkg::RATIO;

  logic clk;
  logic rst_n;
  logic wr_valid;
  logic wr_ready;
  dwc_pkg::wide_wr_t wr;
  logic b_valid;
  logic b_ready;
  dwc_pkg::wide_b_t b;
  logic ar_valid;
  logic ar_ready;
  dwc_pkg::wide_ar_t ar;
  logic r_valid;
  logic r_ready;
  dwc_pkg::wide_r_t r;
  logic nreq_valid;
  logic nreq_ready;
  dwc_pkg::narrow_req_t nreq;
  logic nrsp_valid;
  logic [dwc_pkg::NARROW_W-1:0] nrsp_data;

  // Narrow memory and the expected wide view of it
  logic [dwc_pkg::NARROW_W-1:0] mem [MEM_WORDS];
  logic [dwc_pkg::WIDE_W-1:0] shadow [LINES];

  // Expected responses in issue order
  logic [dwc_pkg::ID_W-1:0] exp_b_id [$];
  logic [dwc_pkg::ID_W-1:0] exp_r_id [$];
  logic [dwc_pkg::WIDE_W-1:0] exp_r_data [$];

  int unsigned data_errs;
  int unsigned proto_errs;
  int unsigned b_seen;
  int unsigned r_seen;
  int unsigned cycle_cnt;
  logic [31:0] stim_seed;
  logic [31:0] bp_seed;
  logic nbp_en;
  logic wbp_en;
  logic [2:0] stretch_cnt;
  logic b_stall;
  logic r_stall;
  dwc_pkg::wide_b_t b_prev;
  dwc_pkg::wide_r_t r_prev;
  logic [dwc_pkg::ID_W-1:0] e_id;
  logic [dwc_pkg::WIDE_W-1:0] e_data;

  dwc_downsizer_top DUT (.*);

  bind dwc_downsizer_top dwc_downsizer_checker u_checker (.*);

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Main stimulus stream used by the main process only
  function automatic logic [31:0] rand32();
    stim_seed = lcg_step(stim_seed);
    return stim_seed;
  endfunction

  // Power-up content with every byte tied to the word address
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5A, idx[7:0] + 8'hC3};
  endfunction

  // Reference model giving the old line with the strobed bytes of a wide write laid over it
  function automatic logic [dwc_pkg::WIDE_W-1:0] merge_write(
      input logic [dwc_pkg::WIDE_W-1:0] old_line,
      input logic [dwc_pkg::WIDE_W-1:0] data,
      input logic [dwc_pkg::WIDE_W/8-1:0] strobe);
    logic [dwc_pkg::WIDE_W-1:0] res;
    res = old_line;
    for (int k = 0; k < dwc_pkg::WIDE_W / 8; k++) begin
      if (strobe[k]) res[8*k +: 8] = data[8*k +: 8];
    end
    return res;
  endfunction

  // One bit per narrow beat spread over its four strobes
  function automatic logic [15:0] expand_beats(input logic [3:0] m);
    return {{4{m[3]}}, {4{m[2]}}, {4{m[1]}}, {4{m[0]}}};
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
    for (int j = 0; j < LINES; j++) begin
      shadow[j] = {fill_word(4*j+3), fill_word(4*j+2), fill_word(4*j+1), fill_word(4*j)};
    end
  end

  // Memory model answering reads exactly one cycle after acceptance
  always @(posedge clk) begin
    nrsp_valid <= 1'b0;
    if (rst_n && nreq_valid && nreq_ready) begin
      if (nreq.op == dwc_pkg::OP_WRITE) begin
        if (nreq.strobe == '0) begin
          proto_errs++;
          $display("Narrow write with no strobe set at %0t ns", $time);
        end
        for (int k = 0; k < 4; k++) begin
          if (nreq.strobe[k]) mem[nreq.addr[9:2]][8*k +: 8] <= nreq.wdata[8*k +: 8];
        end
      end else begin
        nrsp_valid <= 1'b1;
        nrsp_data  <= mem[nreq.addr[9:2]];
      end
    end
  end

  // Ready back-pressure with the wide readies changing in random stretches
  always @(posedge clk) begin
    bp_seed = lcg_step(bp_seed);
    nreq_ready <= !nbp_en || bp_seed[17];
    if (stretch_cnt == 0) begin
      stretch_cnt <= bp_seed[26:24];
      b_ready     <= !wbp_en || bp_seed[21];
      r_ready     <= !wbp_en || bp_seed[22];
    end else begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end
  end

  // Compare process sampling at negedge where all outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (b_stall && (!b_valid || b !== b_prev)) begin
        proto_errs++;
        $display("B response changed before it was accepted at %0t ns", $time);
      end
      if (r_stall && (!r_valid || r !== r_prev)) begin
        proto_errs++;
        $display("R response changed before it was accepted at %0t ns", $time);
      end
      if (b_valid && wr_ready) begin
        proto_errs++;
        $display("wr_ready high while a B response is pending at %0t ns", $time);
      end
      if (r_valid && ar_ready) begin
        proto_errs++;
        $display("ar_ready high while an R response is pending at %0t ns", $time);
      end
      if (b_valid && b_ready) begin
        if (exp_b_id.size() == 0) begin
          proto_errs++;
          $display("B response with no write outstanding at %0t ns", $time);
        end else begin
          e_id = exp_b_id.pop_front();
          b_seen++;
          if (b.id !== e_id) begin
            data_errs++;
            $display("CHECK FAILED at %0t ns: b.id expected %h got %h", $time, e_id, b.id);
          end
        end
      end
      if (r_valid && r_ready) begin
        if (exp_r_id.size() == 0) begin
          proto_errs++;
          $display("R response with no read outstanding at %0t ns", $time);
        end else begin
          e_id   = exp_r_id.pop_front();
          e_data = exp_r_data.pop_front();
          r_seen++;
          if (r.id !== e_id) begin
            data_errs++;
            $display("CHECK FAILED at %0t ns: r.id expected %h got %h", $time, e_id, r.id);
          end
          if (r.data !== e_data) begin
            data_errs++;
            $display("CHECK FAILED at %0t ns: r.data expected %h got %h",
                     $time, e_data, r.data);
          end
        end
      end
      b_stall = b_valid && !b_ready;
      b_prev  = b;
      r_stall = r_valid && !r_ready;
      r_prev  = r;
    end
  end

  // Run limit scaled to the number of transactions
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, transactions did not complete", cycle_cnt);
    $display("Verification failed");
    $finish;
  end

  // Low nibble and upper bits carry the id and the memory ignores both
  task automatic send_write(input logic [3:0] id, input logic [5:0] line,
                            input logic [127:0] data, input logic [15:0] strobe);
    dwc_pkg::wide_wr_t w;
    w.id     = id;
    w.addr   = {18'h0, id, line, id};
    w.data   = data;
    w.strobe = strobe;
    @(posedge clk);
    wr       <= w;
    wr_valid <= 1'b1;
    @(negedge clk);
    while (!wr_ready) @(negedge clk);
    // Accepted on the coming edge
    exp_b_id.push_back(id);
    shadow[line] = merge_write(shadow[line], data, strobe);
    @(posedge clk);
    wr_valid <= 1'b0;
  endtask

  task automatic send_read(input logic [3:0] id, input logic [5:0] line);
    dwc_pkg::wide_ar_t a;
    a.id   = id;
    a.addr = {18'h0, ~id, line, id};
    @(posedge clk);
    ar       <= a;
    ar_valid <= 1'b1;
    @(negedge clk);
    while (!ar_ready) @(negedge clk);
    exp_r_id.push_back(id);
    exp_r_data.push_back(shadow[line]);
    @(posedge clk);
    ar_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (exp_b_id.size() != 0 || exp_r_id.size() != 0) @(negedge clk);
  endtask

  task automatic write_then_read(input logic [3:0] id, input logic [5:0] line,
                                 input logic [127:0] data, input logic [15:0] strobe);
    send_write(id, line, data, strobe);
    wait_idle();
    send_read(id ^ 4'hA, line);
    wait_idle();
  endtask

  initial begin
    logic [31:0] rnd;
    logic [15:0] strb;
    logic [3:0] par_id [N_PAR];
    logic [127:0] par_data [N_PAR];
    logic [15:0] par_strb [N_PAR];
    // Every DUT input starts defined with reset asserted from time zero
    rst_n       <= 1'b0;
    wr_valid    <= 1'b0;
    wr          <= '0;
    ar_valid    <= 1'b0;
    ar          <= '0;
    b_ready     <= 1'b1;
    r_ready     <= 1'b1;
    nreq_ready  <= 1'b1;
    nrsp_valid  <= 1'b0;
    nrsp_data   <= '0;
    stim_seed   = 32'd69999;
    bp_seed     = ~32'd69999;
    nbp_en      = 1'b0;
    wbp_en      = 1'b0;
    stretch_cnt = '0;
    b_stall     = 1'b0;
    r_stall     = 1'b0;
    data_errs   = 0;
    proto_errs  = 0;
    b_seen      = 0;
    r_seen      = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (!wr_ready || !ar_ready || b_valid || r_valid || nreq_valid) begin
      proto_errs++;
      $display("Handshake outputs not at their reset values after reset");
    end

    // Full strobes written and read back
    for (int i = 0; i < N_FULL; i++) begin
      rnd = rand32();
      write_then_read(rnd[3:0], {1'b0, rnd[8:4]},
                      {rand32(), rand32(), rand32(), rand32()}, 16'hFFFF);
    end

    // Random strobes with some beats left empty
    for (int i = 0; i < N_PART; i++) begin
      rnd  = rand32();
      strb = rnd[15:0] & expand_beats(rnd[19:16]);
      write_then_read(rnd[23:20], {1'b0, rnd[28:24]},
                      {rand32(), rand32(), rand32(), rand32()}, strb);
    end
    write_then_read(4'h7, 6'd5, {rand32(), rand32(), rand32(), rand32()}, 16'h0000);

    // Narrow ready drops about half the time from here on
    nbp_en = 1'b1;
    for (int i = 0; i < N_NBP; i++) begin
      rnd  = rand32();
      strb = rnd[31] ? 16'hFFFF : rnd[15:0] & expand_beats(rnd[19:16]);
      write_then_read(rnd[23:20], {1'b0, rnd[28:24]},
                      {rand32(), rand32(), rand32(), rand32()}, strb);
    end

    // Writes to lines 32 up run side by side with reads of untouched lines 48 up
    for (int i = 0; i < N_PAR; i++) begin
      rnd         = rand32();
      par_id[i]   = rnd[3:0];
      par_strb[i] = rnd[4] ? 16'hFFFF : rnd[31:16];
      par_data[i] = {rand32(), rand32(), rand32(), rand32()};
    end
    fork
      for (int i = 0; i < N_PAR; i++) send_write(par_id[i], 6'd32 + i, par_data[i], par_strb[i]);
      for (int i = 0; i < N_PAR; i++) send_read(par_id[i] + 4'd1, 6'd48 + i);
    join
    wait_idle();
    for (int i = 0; i < N_PAR; i++) send_read(par_id[i] ^ 4'h5, 6'd32 + i);
    wait_idle();

    // Wide back-pressure on top of narrow back-pressure
    wbp_en = 1'b1;
    for (int i = 0; i < N_PAR; i++) begin
      rnd         = rand32();
      par_id[i]   = rnd[3:0];
      par_strb[i] = rnd[31:16] & expand_beats(rnd[7:4]);
      par_data[i] = {rand32(), rand32(), rand32(), rand32()};
    end
    fork
      for (int i = 0; i < N_PAR; i++) send_write(par_id[i], 6'd0 + i, par_data[i], par_strb[i]);
      for (int i = 0; i < N_PAR; i++) send_read(par_id[i] ^ 4'hC, 6'd16 + i);
    join
    wait_idle();
    // Lines written under wide back-pressure read back
    for (int i = 0; i < N_PAR; i++) send_read(par_id[i] ^ 4'h3, 6'd0 + i);
    wait_idle();
    repeat (5) @(posedge clk);

    $display("Errors %0d value, %0d other, %0d assertion, %0d B and %0d R checked",
             data_errs, proto_errs, DUT.u_checker.assert_fails, b_seen, r_seen);
    if (data_errs == 0 && proto_errs == 0 && DUT.u_checker.assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verification/dwc_downsizer_checker.sv ====
// ######################################
// Downsizer protocol checker
// Handshake, strobe and reset rules
// bound to the downsizer top level
// ######################################

module dwc_downsizer_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  wr_ready,
  input logic                  ar_ready,
  input logic                  b_valid,
  input logic                  b_ready,
  input dwc_pkg::wide_b_t      b,
  input logic                  r_valid,
  input logic                  r_ready,
  input dwc_pkg::wide_r_t      r,
  input logic                  nreq_valid,
  input logic                  nreq_ready,
  input dwc_pkg::narrow_req_t  nreq,
  input logic                  wr_req_valid,
  input logic                  rd_req_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failure count read by the testbench at the end
  int unsigned assert_fails = 0;

  // Narrow request holds valid and payload through a stall
  narrow_hold: assert property (@(posedge clk) disable iff (!rst_n)
    nreq_valid && !nreq_ready |=> nreq_valid && $stable(nreq))
    else begin
      assert_fails++;
      $error("narrow request dropped or changed before ready");
    end

  // B and R responses wait unchanged for their ready
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
      assert_fails++;
      $error("B response dropped or changed before ready");
    end

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
      assert_fails++;
      $error("R response dropped or changed before ready");
    end

  // Empty beats are skipped and never sent
  write_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    nreq_valid && nreq.op == dwc_pkg::OP_WRITE |-> nreq.strobe != '0)
    else begin
      assert_fails++;
      $error("narrow write sent with all strobes zero");
    end

  // Both paths idle and ready while reset is held
  reset_idle: assert property (@(posedge clk)
    !rst_n |-> wr_ready && ar_ready && !wr_req_valid && !rd_req_valid)
    else begin
      assert_fails++;
      $error("paths not idle during reset");
    end

endmodule

// ==== source/dwc_downsizer_top.sv ====
// ######################################
// Downsizer top level
// Wide write and read paths sharing one
// narrow port through the arbiter
// ######################################

module dwc_downsizer_top (
  input  logic                          clk,
  input  logic                          rst_n,
  // Wide write and B
  input  logic                          wr_valid,
  output logic                          wr_ready,
  input  dwc_pkg::wide_wr_t             wr,
  output logic                          b_valid,
  input  logic                          b_ready,
  output dwc_pkg::wide_b_t              b,
  // Wide read address and R
  input  logic                          ar_valid,
  output logic                          ar_ready,
  input  dwc_pkg::wide_ar_t             ar,
  output logic                          r_valid,
  input  logic                          r_ready,
  output dwc_pkg::wide_r_t              r,
  // Narrow port
  output logic                          nreq_valid,
  input  logic                          nreq_ready,
  output dwc_pkg::narrow_req_t          nreq,
  input  logic                          nrsp_valid,
  input  logic [dwc_pkg::NARROW_W-1:0]  nrsp_data
);

  // Path requests toward the arbiter
  logic                 wr_req_valid;
  logic                 wr_req_ready;
  dwc_pkg::narrow_req_t wr_req;
  logic                 rd_req_valid;
  logic                 rd_req_ready;
  dwc_pkg::narrow_req_t rd_req;

  dwc_write_splitter u_writer (
    .clk (clk), .rst_n (rst_n),
    .wr_valid (wr_valid), .wr_ready (wr_ready), .wr (wr),
    .b_valid (b_valid), .b_ready (b_ready), .b (b),
    .req_valid (wr_req_valid), .req_ready (wr_req_ready), .req (wr_req)
  );

  // Only source of narrow reads, so responses go here directly
  dwc_read_assembler u_reader (
    .clk (clk), .rst_n (rst_n),
    .ar_valid (ar_valid), .ar_ready (ar_ready), .ar (ar),
    .r_valid (r_valid), .r_ready (r_ready), .r (r),
    .req_valid (rd_req_valid), .req_ready (rd_req_ready), .req (rd_req),
    .nrsp_valid (nrsp_valid), .nrsp_data (nrsp_data)
  );

  dwc_narrow_arbiter u_arbiter (
    .clk (clk), .rst_n (rst_n),
    .wr_req_valid (wr_req_valid), .wr_req_ready (wr_req_ready), .wr_req (wr_req),
    .rd_req_valid (rd_req_valid), .rd_req_ready (rd_req_ready), .rd_req (rd_req),
    .nreq_valid (nreq_valid), .nreq_ready (nreq_ready), .nreq (nreq)
  );

endmodule

// ==== source/dwc_narrow_arbiter.sv ====
// ######################################
// Narrow port arbiter
// Round-robin between the write and read
// paths onto the single narrow port
// ######################################

module dwc_narrow_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_req_valid,
  output logic                  wr_req_ready,
  input  dwc_pkg::narrow_req_t  wr_req,
  input  logic                  rd_req_valid,
  output logic                  rd_req_ready,
  input  dwc_pkg::narrow_req_t  rd_req,
  output logic                  nreq_valid,
  input  logic                  nreq_ready,
  output dwc_pkg::narrow_req_t  nreq
);

  // Reader won the last accepted transfer
  logic last_rd_q;
  // Grant kept across a stall so the payload holds until ready
  logic hold_q;
  logic hold_rd_q;

  logic fair_rd;
  logic grant_rd;
  logic grant_wr;

  // On a tie the side not served last goes first
  assign fair_rd  = rd_req_valid && (!wr_req_valid || !last_rd_q);
  assign grant_rd = hold_q ? hold_rd_q : fair_rd;
  assign grant_wr = wr_req_valid && !grant_rd;

  assign nreq_valid = wr_req_valid || rd_req_valid;
  assign nreq       = grant_rd ? rd_req : wr_req;

  // Ready back to the granted side only
  assign wr_req_ready = nreq_ready && grant_wr;
  assign rd_req_ready = nreq_ready && grant_rd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_rd_q <= 1'b0;
      hold_q    <= 1'b0;
      hold_rd_q <= 1'b0;
    end else begin
      if (nreq_valid && nreq_ready) begin
        last_rd_q <= grant_rd;
        hold_q    <= 1'b0;
      end else if (nreq_valid) begin
        // Freeze the choice across a stall
        hold_q    <= 1'b1;
        hold_rd_q <= grant_rd;
      end
    end
  end

endmodule

// ==== source/dwc_read_assembler.sv ====
// ######################################
// Read assembler
// Issues the narrow reads of one wide
// read and packs the words onto R
// ######################################

module dwc_read_assembler (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ar_valid,
  output logic                          ar_ready,
  input  dwc_pkg::wide_ar_t             ar,
  output logic                          r_valid,
  input  logic                          r_ready,
  output dwc_pkg::wide_r_t              r,
  output logic                          req_valid,
  input  logic                          req_ready,
  output dwc_pkg::narrow_req_t          req,
  input  logic                          nrsp_valid,
  input  logic [dwc_pkg::NARROW_W-1:0]  nrsp_data
);

  dwc_pkg::asm_state_e state_q;

  // Payload of the accepted request
  dwc_pkg::wide_ar_t ar_q;

  // Assembled wide word
  logic [dwc_pkg::WIDE_W-1:0] data_q;

  // Issued and received beats count apart so responses overlap issue
  logic [dwc_pkg::BEAT_IDX_W-1:0] issue_cnt_q;
  logic [dwc_pkg::BEAT_IDX_W-1:0] recv_cnt_q;

  // Last beat of each kind
  logic issue_last;
  logic recv_last;

  assign issue_last = (issue_cnt_q == dwc_pkg::BEAT_IDX_W'(dwc_pkg::RATIO - 1));
  assign recv_last  = (recv_cnt_q == dwc_pkg::BEAT_IDX_W'(dwc_pkg::RATIO - 1));

  assign ar_ready  = (state_q == dwc_pkg::ASM_IDLE);
  assign req_valid = (state_q == dwc_pkg::ASM_ISSUE);
  assign r_valid   = (state_q == dwc_pkg::ASM_RESP);

  assign r.id   = ar_q.id;
  assign r.data = data_q;

  // Narrow read of the beat at the issue counter
  always_comb begin
    req.op     = dwc_pkg::OP_READ;
    req.addr   = {ar_q.addr[dwc_pkg::ADDR_W-1:dwc_pkg::BEAT_IDX_W+dwc_pkg::NARROW_OFF_W],
                  issue_cnt_q, {dwc_pkg::NARROW_OFF_W{1'b0}}};
    // No write data on reads
    req.wdata  = '0;
    req.strobe = '0;
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) ar_q <= ar;
    // Words land in slots by arrival order
    if (nrsp_valid) data_q[recv_cnt_q*dwc_pkg::NARROW_W +: dwc_pkg::NARROW_W] <= nrsp_data;
  end

  // Response counter runs in ISSUE and WAIT alike
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      recv_cnt_q <= '0;
    end else if (ar_valid && ar_ready) begin
      recv_cnt_q <= '0;
    end else if (nrsp_valid) begin
      recv_cnt_q <= recv_cnt_q + 1'b1;
    end
  end

  // Control FSM and issue counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= dwc_pkg::ASM_IDLE;
      issue_cnt_q <= '0;
    end else begin
      case (state_q)
        dwc_pkg::ASM_IDLE: begin
          if (ar_valid) begin
            issue_cnt_q <= '0;
            state_q     <= dwc_pkg::ASM_ISSUE;
          end
        end
        dwc_pkg::ASM_ISSUE: begin
          // Back to back as the arbiter lets us
          if (req_ready) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
            if (issue_last) state_q <= dwc_pkg::ASM_WAIT;
          end
        end
        dwc_pkg::ASM_WAIT: begin
          // Final word arrives one cycle after the last issue at the earliest
          if (nrsp_valid && recv_last) state_q <= dwc_pkg::ASM_RESP;
        end
        dwc_pkg::ASM_RESP: begin
          if (r_ready) state_q <= dwc_pkg::ASM_IDLE;
        end
        default: state_q <= dwc_pkg::ASM_IDLE;
      endcase
    end
  end

endmodule

// ==== source/dwc_write_splitter.sv ====
// ######################################
// Write splitter
// Breaks one wide write into narrow
// writes, skips empty beats, answers on B
// ######################################

module dwc_write_splitter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_valid,
  output logic                  wr_ready,
  input  dwc_pkg::wide_wr_t     wr,
  output logic                  b_valid,
  input  logic                  b_ready,
  output dwc_pkg::wide_b_t      b,
  output logic                  req_valid,
  input  logic                  req_ready,
  output dwc_pkg::narrow_req_t  req
);

  dwc_pkg::split_state_e state_q;

  // Payload of the accepted write
  dwc_pkg::wide_wr_t wr_q;

  // Beats still to send with one bit per narrow word
  logic [dwc_pkg::RATIO-1:0] pend_q;
  logic [dwc_pkg::RATIO-1:0] wr_nz;
  logic [dwc_pkg::RATIO-1:0] pend_left;
  logic [dwc_pkg::BEAT_IDX_W-1:0] beat_idx;

  // A beat counts only if any of its byte strobes is set
  always_comb begin
    for (int k = 0; k < dwc_pkg::RATIO; k++) begin
      wr_nz[k] = |wr.strobe[k*dwc_pkg::NARROW_STRB_W +: dwc_pkg::NARROW_STRB_W];
    end
  end

  // Lowest pending beat goes first, so beats leave in address order
  always_comb begin
    beat_idx = '0;
    for (int k = dwc_pkg::RATIO - 1; k >= 0; k--) begin
      if (pend_q[k]) beat_idx = dwc_pkg::BEAT_IDX_W'(k);
    end
  end

  // Pending mask once the current beat is gone
  assign pend_left = pend_q & ~(dwc_pkg::RATIO'(1) << beat_idx);

  // Handshake outputs straight from the state
  assign wr_ready  = (state_q == dwc_pkg::SPLIT_IDLE);
  assign req_valid = (state_q == dwc_pkg::SPLIT_SEND);
  assign b_valid   = (state_q == dwc_pkg::SPLIT_RESP);
  assign b.id      = wr_q.id;

  // Narrow write for the current beat
  always_comb begin
    req.op     = dwc_pkg::OP_WRITE;
    req.addr   = {wr_q.addr[dwc_pkg::ADDR_W-1:dwc_pkg::BEAT_IDX_W+dwc_pkg::NARROW_OFF_W],
                  beat_idx, {dwc_pkg::NARROW_OFF_W{1'b0}}};
    req.wdata  = wr_q.data[beat_idx*dwc_pkg::NARROW_W +: dwc_pkg::NARROW_W];
    req.strobe = wr_q.strobe[beat_idx*dwc_pkg::NARROW_STRB_W +: dwc_pkg::NARROW_STRB_W];
  end

  always_ff @(posedge clk) begin
    if (wr_valid && wr_ready) wr_q <= wr;
  end

  // Control FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= dwc_pkg::SPLIT_IDLE;
      pend_q  <= '0;
    end else begin
      case (state_q)
        dwc_pkg::SPLIT_IDLE: begin
          // All-zero strobes go straight to the response
          if (wr_valid) begin
            pend_q  <= wr_nz;
            state_q <= (|wr_nz) ? dwc_pkg::SPLIT_SEND : dwc_pkg::SPLIT_RESP;
          end
        end
        dwc_pkg::SPLIT_SEND: begin
          if (req_ready) begin
            pend_q <= pend_left;
            if (pend_left == '0) state_q <= dwc_pkg::SPLIT_RESP;
          end
        end
        dwc_pkg::SPLIT_RESP: begin
          if (b_ready) state_q <= dwc_pkg::SPLIT_IDLE;
        end
        default: state_q <= dwc_pkg::SPLIT_IDLE;
      endcase
    end
  end

endmodule

// ==== source/dwc_pkg.sv ====
// ######################################
// Data width downsizer package
// Widths, channel payloads and the FSM
// state encodings shared by all blocks
// ######################################

package dwc_pkg;

  // Address and id widths
  localparam int ADDR_W = 32;
  localparam int ID_W = 4;

  // Narrow side word and the wide/narrow ratio
  localparam int NARROW_W = 32;
  localparam int RATIO = 4;
  localparam int WIDE_W = NARROW_W * RATIO;

  // Beat counter stepping once per narrow word
  localparam int BEAT_IDX_W = 2;

  // Byte strobes per narrow word and byte offset bits inside it
  localparam int NARROW_STRB_W = NARROW_W / 8;
  localparam int NARROW_OFF_W = $clog2(NARROW_W / 8);

  // Narrow operation
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Wide write carrying address and data in one beat
  typedef struct packed {
    logic [ID_W-1:0]       id;
    logic [ADDR_W-1:0]     addr;
    logic [WIDE_W-1:0]     data;
    logic [WIDE_W/8-1:0]   strobe;
  } wide_wr_t;

  // Wide read request
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
  } wide_ar_t;

  // Write response carrying only the id since errors are not modelled
  typedef struct packed {
    logic [ID_W-1:0] id;
  } wide_b_t;

  // Read response carrying the assembled wide word
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [WIDE_W-1:0] data;
  } wide_r_t;

  // Request on the narrow port
  typedef struct packed {
    op_e                      op;
    logic [ADDR_W-1:0]        addr;
    logic [NARROW_W-1:0]      wdata;
    logic [NARROW_STRB_W-1:0] strobe;
  } narrow_req_t;

  // Write splitter states
  typedef enum logic [1:0] {
    SPLIT_IDLE = 2'd0,
    SPLIT_SEND = 2'd1,
    SPLIT_RESP = 2'd2
  } split_state_e;

  // Read assembler states
  typedef enum logic [1:0] {
    ASM_IDLE  = 2'd0,
    ASM_ISSUE = 2'd1,
    ASM_WAIT  = 2'd2,
    ASM_RESP  = 2'd3
  } asm_state_e;

endpackage
